// File: accel_macros.svh
`ifndef ACCEL_MACROS_SVH
`define ACCEL_MACROS_SVH

`define ACCEL_I2C_ADDR 7'h1D
`define I2C_QUARTER 4

`define REG_POWER_CTL 8'h2D
`define REG_INT_ENABLE 8'h2E
`define REG_INT_MAP 8'h2F
`define REG_DATA_FORMAT 8'h31
`define REG_DATAX0 8'h32

// Measure mode on, full resolution at 16 g, data-ready interrupt on int1.
`define CFG_POWER_CTL 8'h08
`define CFG_DATA_FORMAT 8'h0B
`define CFG_INT_ENABLE 8'h80
`define CFG_INT_MAP 8'h00

`define SAMPLE_BYTES 6

`endif

// File: accel_pkg.sv
`include "accel_macros.svh"

package accel_pkg;

	typedef struct packed {
		logic rd; // Burst read when set, single write otherwise.
		logic [7:0] reg_addr;
		logic [7:0] wdata;
		logic [2:0] nbytes; // Read length, 1 to 6.
	} i2c_cmd_t;

	typedef struct packed {
		logic ok;
		logic nack;
	} i2c_result_t;

	typedef struct packed {
		logic signed [15:0] z;
		logic signed [15:0] y;
		logic signed [15:0] x;
	} accel_axes_t;

	// The sensor sends every axis low byte first, so both views line up.
	typedef union packed {
		logic [`SAMPLE_BYTES-1:0][7:0] bytes;
		accel_axes_t axes;
	} accel_raw_u;

	typedef enum logic {
		cfg = 1'b0,
		smp = 1'b1
	} client_t;

endpackage

// File: i2c_master.sv
`timescale 1ns/1ps
`include "accel_macros.svh"

module i2c_master (
	input logic clk,
	input logic rst,
	input logic start,
	input accel_pkg::i2c_cmd_t cmd,
	output logic busy,
	output logic done,
	output accel_pkg::i2c_result_t result,
	output logic [7:0] rd_byte,
	output logic rd_strobe,
	output logic nack_seen,
	output logic scl,
	output logic sda_low,
	input logic sda_in
);

	localparam int PHASE_W = $clog2(`I2C_QUARTER);

	typedef enum logic [2:0] {
		st_idle,
		st_start,
		st_tx,
		st_ack_rx,
		st_rstart,
		st_rx,
		st_ack_tx,
		st_stop
	} state_t;

	state_t state;
	accel_pkg::i2c_cmd_t cmd_q;
	logic [PHASE_W-1:0] phase;
	logic [1:0] quarter;
	logic [2:0] bit_cnt;
	logic [2:0] byte_cnt;
	logic [1:0] tx_idx; // Which byte of the write part is on the wire.
	logic rd_phase;
	logic nack_q;
	logic [7:0] sreg;
	logic tick;
	logic bit_end;
	logic samp;
	logic last;
	logic scl_c;
	logic sda_c;

	assign tick = (phase == PHASE_W'(`I2C_QUARTER - 1));
	assign bit_end = tick && (quarter == 2'd3);
	assign samp = (phase == '0) && (quarter == 2'd1); // SCL rises on the pin at the end of this cycle.
	assign last = (byte_cnt == cmd_q.nbytes);
	assign busy = (state != st_idle);

	// ****************************************
	// Bus levels per quarter bit
	// ****************************************
	always_comb begin
		scl_c = 1'b1;
		sda_c = 1'b0;
		case (state)
			st_start: begin
				scl_c = (quarter != 2'd3);
				sda_c = quarter[1]; // Falls while SCL is high.
			end
			st_rstart: begin
				scl_c = quarter[0] ^ quarter[1];
				sda_c = quarter[1];
			end
			st_tx: begin
				scl_c = quarter[0] ^ quarter[1];
				sda_c = !sreg[7];
			end
			st_ack_tx: begin
				scl_c = quarter[0] ^ quarter[1];
				sda_c = !last; // The last byte gets a NACK.
			end
			st_rx, st_ack_rx: begin
				scl_c = quarter[0] ^ quarter[1];
			end
			st_stop: begin
				scl_c = (quarter != 2'd0);
				sda_c = !quarter[1]; // Rises while SCL is high.
			end
			default: ;
		endcase
	end

	// ****************************************
	// Sequencer
	// ****************************************
	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= st_idle;
			phase <= '0;
			quarter <= 2'd0;
			bit_cnt <= 3'd0;
			byte_cnt <= 3'd0;
			tx_idx <= 2'd0;
			rd_phase <= 1'b0;
			nack_q <= 1'b0;
			nack_seen <= 1'b0;
			done <= 1'b0;
			rd_strobe <= 1'b0;
			scl <= 1'b1;
			sda_low <= 1'b0;
		end else begin
			done <= 1'b0;
			rd_strobe <= 1'b0;
			scl <= scl_c;
			sda_low <= sda_c;
			phase <= (state == st_idle || tick) ? '0 : phase + 1'b1;
			if (state == st_idle) begin
				quarter <= 2'd0;
			end else if (tick) begin
				quarter <= quarter + 2'd1;
			end
			case (state)
				st_idle: if (start) begin
					state <= st_start;
					bit_cnt <= 3'd0;
					byte_cnt <= 3'd0;
					tx_idx <= 2'd0;
					rd_phase <= 1'b0;
					nack_q <= 1'b0;
				end
				st_start: if (bit_end) state <= st_tx;
				st_tx: if (bit_end) begin
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7) state <= st_ack_rx;
				end
				st_ack_rx: begin
					if (samp && sda_in) begin
						nack_q <= 1'b1;
						nack_seen <= 1'b1;
					end
					if (bit_end) begin
						tx_idx <= tx_idx + 2'd1;
						if (nack_q) state <= st_stop;
						else if (tx_idx == 2'd0 && rd_phase) state <= st_rx;
						else if (tx_idx == 2'd1 && cmd_q.rd) state <= st_rstart;
						else if (tx_idx == 2'd2) state <= st_stop;
						else state <= st_tx;
					end
				end
				st_rstart: if (bit_end) begin
					state <= st_tx;
					tx_idx <= 2'd0;
					rd_phase <= 1'b1;
				end
				st_rx: begin
					if (samp && bit_cnt == 3'd7) begin
						rd_strobe <= 1'b1;
						byte_cnt <= byte_cnt + 3'd1;
					end
					if (bit_end) begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) state <= st_ack_tx;
					end
				end
				st_ack_tx: if (bit_end) state <= last ? st_stop : st_rx;
				st_stop: if (bit_end) begin
					state <= st_idle;
					done <= 1'b1;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && start) begin
			cmd_q <= cmd;
			sreg <= {`ACCEL_I2C_ADDR, 1'b0};
		end else if (state == st_tx && bit_end) begin
			sreg <= {sreg[6:0], 1'b0};
		end else if (state == st_ack_rx && bit_end) begin
			sreg <= (tx_idx == 2'd0) ? cmd_q.reg_addr : cmd_q.wdata;
		end else if (state == st_rstart && bit_end) begin
			sreg <= {`ACCEL_I2C_ADDR, 1'b1};
		end else if (state == st_rx && samp) begin
			sreg <= {sreg[6:0], sda_in};
		end
		if (state == st_rx && samp && bit_cnt == 3'd7) rd_byte <= {sreg[6:0], sda_in};
		if (state == st_stop && bit_end) begin
			result.ok <= !nack_q;
			result.nack <= nack_q;
		end
	end

endmodule

// File: i2c_arbiter.sv
`timescale 1ns/1ps

module i2c_arbiter (
	input logic clk,
	input logic rst,
	input logic cfg_req,
	input accel_pkg::i2c_cmd_t cfg_cmd,
	output logic cfg_done,
	input logic smp_req,
	input accel_pkg::i2c_cmd_t smp_cmd,
	output logic smp_done,
	input logic result_done,
	output accel_pkg::client_t owner,
	output logic start,
	output accel_pkg::i2c_cmd_t cmd
);

	logic gnt;
	logic issued; // Start already sent for this grant.

	always_ff @(posedge clk) begin
		if (!rst) begin
			gnt <= 1'b0;
			issued <= 1'b0;
			start <= 1'b0;
			owner <= accel_pkg::cfg;
		end else begin
			start <= 1'b0;
			if (!gnt) begin
				if (cfg_req || smp_req) begin
					gnt <= 1'b1;
					issued <= 1'b0;
					owner <= cfg_req ? accel_pkg::cfg : accel_pkg::smp; // Configurator first.
				end
			end else begin
				if (!issued) begin
					start <= 1'b1;
					issued <= 1'b1;
				end
				if (result_done) gnt <= 1'b0;
			end
		end
	end

	assign cmd = (owner == accel_pkg::smp) ? smp_cmd : cfg_cmd;
	assign cfg_done = result_done && gnt && (owner == accel_pkg::cfg);
	assign smp_done = result_done && gnt && (owner == accel_pkg::smp);

endmodule

// File: accel_config.sv
`timescale 1ns/1ps
`include "accel_macros.svh"

module accel_config (
	input logic clk,
	input logic rst,
	output logic req,
	output accel_pkg::i2c_cmd_t cmd,
	input logic done,
	input accel_pkg::i2c_result_t result,
	output logic ready
);

	logic [1:0] idx;

	// ****************************************
	// Setup table
	// ****************************************
	always_comb begin
		cmd = '0;
		cmd.nbytes = 3'd1;
		case (idx)
			2'd0: begin
				cmd.reg_addr = `REG_POWER_CTL;
				cmd.wdata = `CFG_POWER_CTL;
			end
			2'd1: begin
				cmd.reg_addr = `REG_DATA_FORMAT;
				cmd.wdata = `CFG_DATA_FORMAT;
			end
			2'd2: begin
				cmd.reg_addr = `REG_INT_MAP;
				cmd.wdata = `CFG_INT_MAP;
			end
			default: begin
				cmd.reg_addr = `REG_INT_ENABLE; // Interrupts go on only once routed.
				cmd.wdata = `CFG_INT_ENABLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			idx <= 2'd0;
			req <= 1'b0;
			ready <= 1'b0;
		end else if (done) begin
			req <= 1'b0;
			if (result.ok) begin
				idx <= idx + 2'd1;
				if (idx == 2'd3) ready <= 1'b1;
			end
		end else if (!req && !ready) begin
			req <= 1'b1; // Also retries a register that got no acknowledge.
		end
	end

endmodule

// File: accel_sampler.sv
`timescale 1ns/1ps
`include "accel_macros.svh"

module accel_sampler (
	input logic clk,
	input logic rst,
	input logic ready,
	input logic int1,
	output logic req,
	output accel_pkg::i2c_cmd_t cmd,
	input logic owned,
	input logic done,
	input accel_pkg::i2c_result_t result,
	input logic [7:0] rd_byte,
	input logic rd_strobe,
	output accel_pkg::accel_axes_t sample,
	output logic sample_valid
);

	logic int1_meta;
	logic int1_sync;
	logic int1_prev;
	logic rise;
	logic pending;
	logic [2:0] byte_idx;
	accel_pkg::accel_raw_u raw;

	assign rise = int1_sync && !int1_prev;

	always_comb begin
		cmd = '0;
		cmd.rd = 1'b1;
		cmd.reg_addr = `REG_DATAX0;
		cmd.nbytes = 3'(`SAMPLE_BYTES);
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			int1_meta <= 1'b0;
			int1_sync <= 1'b0;
			int1_prev <= 1'b0;
			pending <= 1'b0;
			req <= 1'b0;
			byte_idx <= 3'd0;
			sample_valid <= 1'b0;
		end else begin
			int1_meta <= int1;
			int1_sync <= int1_meta;
			int1_prev <= int1_sync;
			sample_valid <= done && result.ok;
			if (owned && rd_strobe) byte_idx <= byte_idx + 3'd1;
			if (req) begin
				if (done) req <= 1'b0;
				if (rise && ready) pending <= 1'b1; // Keep one edge for the next burst.
			end else if (pending || (rise && ready)) begin
				req <= 1'b1;
				pending <= 1'b0;
				byte_idx <= 3'd0;
			end
		end
	end

	// ****************************************
	// Burst assembly
	// ****************************************
	always_ff @(posedge clk) begin
		if (owned && rd_strobe) raw.bytes[byte_idx] <= rd_byte;
		if (done && result.ok) sample <= raw.axes; // A NACKed burst is dropped.
	end

endmodule

// File: accel_top.sv
`timescale 1ns/1ps

module accel_top (
	input logic clk,
	input logic rst,
	input logic int1,
	output logic sclk,
	inout wire sda,
	output logic cs_n,
	output logic sdo,
	output logic ready,
	output accel_pkg::accel_axes_t sample,
	output logic sample_valid,
	output logic nack_seen
);

	logic cfg_req;
	accel_pkg::i2c_cmd_t cfg_cmd;
	logic cfg_done;
	logic smp_req;
	accel_pkg::i2c_cmd_t smp_cmd;
	logic smp_done;
	logic smp_owned;
	accel_pkg::client_t owner;
	logic start;
	accel_pkg::i2c_cmd_t cmd;
	logic busy;
	logic done;
	accel_pkg::i2c_result_t result;
	logic [7:0] rd_byte;
	logic rd_strobe;
	logic sda_low;

	// ****************************************
	// Pins
	// ****************************************
	assign cs_n = 1'b1; // I2C mode.
	assign sdo = 1'b1; // Primary address.
	assign sda = sda_low ? 1'b0 : 1'bz;
	assign smp_owned = (owner == accel_pkg::smp);

	accel_config accel_config_inst (.clk(clk), .rst(rst), .req(cfg_req), .cmd(cfg_cmd),
		.done(cfg_done), .result(result), .ready(ready));

	accel_sampler accel_sampler_inst (.clk(clk), .rst(rst), .ready(ready), .int1(int1),
		.req(smp_req), .cmd(smp_cmd), .owned(smp_owned), .done(smp_done), .result(result),
		.rd_byte(rd_byte), .rd_strobe(rd_strobe), .sample(sample), .sample_valid(sample_valid));

	i2c_arbiter i2c_arbiter_inst (.clk(clk), .rst(rst), .cfg_req(cfg_req), .cfg_cmd(cfg_cmd),
		.cfg_done(cfg_done), .smp_req(smp_req), .smp_cmd(smp_cmd), .smp_done(smp_done),
		.result_done(done), .owner(owner), .start(start), .cmd(cmd));

	i2c_master i2c_master_inst (.clk(clk), .rst(rst), .start(start), .cmd(cmd), .busy(busy),
		.done(done), .result(result), .rd_byte(rd_byte), .rd_strobe(rd_strobe),
		.nack_seen(nack_seen), .scl(sclk), .sda_low(sda_low), .sda_in(sda));

endmodule

// File: accel_slave_model.sv
`timescale 1ns/1ps
`include "accel_macros.svh"

module accel_slave_model (
	input logic scl,
	inout wire sda,
	input logic [47:0] data,
	input logic ignore_addr
);

	logic oe;
	logic active;
	logic selected;
	logic rw;
	logic sending;
	logic [7:0] sr;
	logic [7:0] reg_ptr;
	logic [7:0] wr_reg [16];
	logic [7:0] wr_val [16];
	int bitc;
	int byte_no;
	int rd_idx;
	int wr_count = 0;
	int start_count = 0;
	int rstart_count = 0;
	int stop_count = 0;
	int mack_count = 0;
	int mnack_count = 0;

	assign sda = oe ? 1'b0 : 1'bz;

	initial begin
		oe = 1'b0;
		active = 1'b0;
		selected = 1'b0;
		sending = 1'b0;
		rw = 1'b0;
		reg_ptr = 8'h00;
	end

	// ****************************************
	// START and STOP detection
	// ****************************************
	always @(negedge sda) if (scl === 1'b1) begin
		if (active) rstart_count++;
		else start_count++;
		active = 1'b1;
		bitc = 0;
		byte_no = 0;
		sending = 1'b0;
		selected = 1'b0;
		oe = 1'b0;
	end

	always @(posedge sda) if (scl === 1'b1 && active) begin
		stop_count++;
		active = 1'b0;
		selected = 1'b0;
		sending = 1'b0;
		oe = 1'b0;
	end

	always @(posedge scl) if (active) begin
		if (bitc < 8) begin
			if (!sending) sr = {sr[6:0], (sda === 1'b0) ? 1'b0 : 1'b1};
			if (bitc == 7 && !sending) begin
				if (byte_no == 0) begin
					selected = (sr[7:1] == `ACCEL_I2C_ADDR) && !ignore_addr;
					rw = sr[0];
				end else if (selected && byte_no == 1) begin
					reg_ptr = sr;
				end else if (selected && wr_count < 16) begin
					wr_reg[wr_count] = reg_ptr; // Register writes are logged in order.
					wr_val[wr_count] = sr;
					wr_count++;
					reg_ptr++;
				end
			end
			bitc++;
		end else begin
			if (sending) begin
				if (sda === 1'b0) begin
					mack_count++;
					rd_idx++;
				end else begin
					mnack_count++;
					sending = 1'b0;
				end
			end else if (selected && byte_no == 0 && rw) begin
				sending = 1'b1;
				rd_idx = reg_ptr - `REG_DATAX0;
			end
			bitc = 0;
			byte_no++;
		end
	end

	// The slave only moves SDA while SCL is low.
	always @(negedge scl) if (active) begin
		if (bitc == 8) oe = !sending && selected;
		else if (sending && rd_idx < 6) oe = !data[rd_idx * 8 + (7 - bitc)];
		else oe = 1'b0;
	end

endmodule

// File: accel_chk.sv
`timescale 1ns/1ps

module accel_chk (
	input logic clk,
	input logic rst,
	input logic start,
	input logic busy,
	input logic done,
	input accel_pkg::client_t owner,
	input logic [2:0] mstate,
	input logic sclk,
	input logic sda
);

	a_start_idle: assert property (@(posedge clk) disable iff (!rst) start |-> !busy)
		else $error("start while master busy");
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
		else $error("done longer than one cycle");
	a_owner_held: assert property (@(posedge clk) disable iff (!rst) busy |-> $stable(owner))
		else $error("owner changed during a transaction");

	// States 1, 4 and 7 are START, repeated START and STOP in the master FSM.
	a_sda_stable: assert property (@(posedge clk) disable iff (!rst)
		(sclk && $past(sclk) && (sda !== $past(sda))) |->
		(mstate == 3'd1 || mstate == 3'd4 || mstate == 3'd7))
		else $error("SDA moved while SCL high outside START or STOP");

endmodule

// File: accel_tb.sv
`timescale 1ns/1ps
`include "accel_macros.svh"

module accel_tb;

	localparam int NROWS = 8;
	localparam int LIMIT = (NROWS + 1) * 120 * 4 * `I2C_QUARTER;

	logic clk = 1'b0;
	logic rst;
	logic int1;
	wire sclk;
	wire sda;
	logic cs_n;
	logic sdo;
	logic ready;
	accel_pkg::accel_axes_t sample;
	logic sample_valid;
	logic nack_seen;
	logic [47:0] model_data;
	logic model_ignore;
	accel_pkg::accel_axes_t row_axes [NROWS];
	logic row_nack [NROWS];
	int errors = 0;
	int cycles = 0;
	int valid_count = 0;

	pullup (sda);

	accel_top accel_top_inst (.clk(clk), .rst(rst), .int1(int1), .sclk(sclk), .sda(sda),
		.cs_n(cs_n), .sdo(sdo), .ready(ready), .sample(sample), .sample_valid(sample_valid),
		.nack_seen(nack_seen));

	accel_slave_model slave_inst (.scl(sclk), .sda(sda), .data(model_data),
		.ignore_addr(model_ignore));

	bind accel_top accel_chk accel_chk_inst (.clk(clk), .rst(rst), .start(start), .busy(busy),
		.done(done), .owner(owner), .mstate(i2c_master_inst.state), .sclk(sclk), .sda(sda));

	always #10 clk = !clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (sample_valid) valid_count <= valid_count + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("sim failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_axes(input string name, input accel_pkg::accel_axes_t got,
		input accel_pkg::accel_axes_t exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_write(input int idx, input logic [7:0] got_reg, input logic [7:0] got_val,
		input logic [7:0] exp_reg, input logic [7:0] exp_val);
		if (got_reg !== exp_reg || got_val !== exp_val) begin
			$display("error write[%0d] got %h=%h expected %h=%h", idx, got_reg, got_val,
				exp_reg, exp_val);
			errors++;
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report(input int num, input string name, input int err_before);
		$display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "bad");
	endtask

	initial begin
		logic [31:0] seed;
		logic [7:0] exp_reg [4];
		logic [7:0] exp_val [4];
		int e0;
		int n_before;
		int v_before;
		int a_before;
		int k_before;
		logic nack_exp;
		int good_reads;

		// ****************************************
		// Stimulus table
		// ****************************************
		row_axes[0] = '{z: 16'sh0100, y: 16'shff80, x: 16'sh0012};
		row_nack[0] = 1'b0;
		row_axes[1] = '{z: 16'sh7fff, y: 16'sh8000, x: 16'sh1234};
		row_nack[1] = 1'b0;
		row_axes[2] = '{z: 16'sh0aa5, y: 16'sh5a5a, x: 16'shc3c3};
		row_nack[2] = 1'b1; // Sensor ignores its address on this row.
		seed = 32'h3cd570d8;
		for (int r = 3; r < NROWS; r++) begin
			seed = lcg_next(seed);
			row_axes[r].x = seed[31:16];
			seed = lcg_next(seed);
			row_axes[r].y = seed[31:16];
			seed = lcg_next(seed);
			row_axes[r].z = seed[31:16];
			row_nack[r] = 1'b0;
		end
		exp_reg = '{`REG_POWER_CTL, `REG_DATA_FORMAT, `REG_INT_MAP, `REG_INT_ENABLE};
		exp_val = '{`CFG_POWER_CTL, `CFG_DATA_FORMAT, `CFG_INT_MAP, `CFG_INT_ENABLE};

		rst = 1'b0;
		int1 = 1'b0;
		model_data = '0;
		model_ignore = 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b1;

		// An interrupt edge long before configuration ends.
		repeat (10) @(posedge clk);
		int1 <= 1'b1;
		repeat (4) @(posedge clk);
		int1 <= 1'b0;

		e0 = errors;
		check_level("cs_n", cs_n, 1'b1);
		check_level("sdo", sdo, 1'b1);
		while (slave_inst.wr_count < 4) @(posedge clk);
		check_level("ready", ready, 1'b0); // The fourth write has not finished yet.
		while (!ready) @(posedge clk);
		repeat (2) @(posedge clk);
		check_count("wr_count", slave_inst.wr_count, 4);
		for (int i = 0; i < 4; i++)
			check_write(i, slave_inst.wr_reg[i], slave_inst.wr_val[i], exp_reg[i], exp_val[i]);
		report(1, "configuration", e0);

		e0 = errors;
		repeat (20) @(posedge clk);
		check_count("valid_count", valid_count, 0);
		check_count("rstart_count", slave_inst.rstart_count, 0);
		check_count("start_count", slave_inst.start_count, 4);
		report(2, "early interrupt", e0);

		nack_exp = 1'b0;
		good_reads = 0;
		for (int r = 0; r < NROWS; r++) begin
			e0 = errors;
			@(posedge clk);
			model_data <= row_axes[r];
			model_ignore <= row_nack[r];
			n_before = slave_inst.stop_count;
			v_before = valid_count;
			a_before = slave_inst.mack_count;
			k_before = slave_inst.mnack_count;
			@(posedge clk);
			int1 <= 1'b1;
			repeat (4) @(posedge clk);
			int1 <= 1'b0;
			while (slave_inst.stop_count == n_before) @(posedge clk);
			if (!row_nack[r]) begin
				while (valid_count == v_before) @(posedge clk);
			end
			repeat (8 * `I2C_QUARTER) @(posedge clk); // Two bit times for a late or extra pulse.
			if (row_nack[r]) begin
				nack_exp = 1'b1;
				check_count("sample_valid pulses", valid_count - v_before, 0);
				check_count("master acks", slave_inst.mack_count - a_before, 0);
			end else begin
				good_reads++;
				check_count("sample_valid pulses", valid_count - v_before, 1);
				check_axes("sample", sample, row_axes[r]);
				check_count("master acks", slave_inst.mack_count - a_before, 5);
				check_count("master nacks", slave_inst.mnack_count - k_before, 1);
			end
			check_level("nack_seen", nack_seen, nack_exp);
			report(3 + r, row_nack[r] ? "missed acknowledge" : "sample read", e0);
		end

		e0 = errors;
		check_count("start_count", slave_inst.start_count, 4 + NROWS);
		check_count("stop_count", slave_inst.stop_count, 4 + NROWS);
		check_count("rstart_count", slave_inst.rstart_count, good_reads);
		check_count("mnack_count", slave_inst.mnack_count, good_reads);
		check_level("ready", ready, 1'b1);
		report(3 + NROWS, "bus protocol", e0);

		$display("tests %0d errors %0d", 3 + NROWS, errors);
		if (errors == 0) $display("sim passed");
		else $display("sim failed");
		$finish;
	end

endmodule

// File: all.f
+incdir+.
accel_pkg.sv
i2c_master.sv
i2c_arbiter.sv
accel_config.sv
accel_sampler.sv
accel_top.sv
accel_slave_model.sv
accel_chk.sv
accel_tb.sv
